// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_exc_unit
FILELIST  = exc_unit_top.f
OBJ_DIR   = obj_dir
SIM_FLAGS = +verilator+error+limit+1000
LOG       = sim.log
FAIL_MSG  = Test failures found

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, search the log for failures"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) $(SIM_FLAGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG) || [ $$status -ne 0 ]; then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== cp0_regs.sv ====
`timescale 1ns/1ps

module cp0_regs import cpu_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  exc_info_t  commit_info,
	input  logic [5:0] hw_int,
	output word_t      status,
	output word_t      cause,
	output vaddr_t     epc,
	output vaddr_t     badvaddr
);

	logic take_exc;
	logic do_eret;
	logic do_mtc0;
	logic write_badva;

	assign take_exc    = commit_info.is_valid_exc;
	assign do_eret     = (commit_info.cp0_op == OP_ERET);
	assign do_mtc0     = (commit_info.cp0_op == OP_MTC0);
	assign write_badva = (commit_info.cp0_op == OP_BADVA)
		|| (commit_info.cp0_op == OP_TLB_EXC);

	////////////////////////////////////////////////////////////
	// Status
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			status <= STATUS_RESET;
		end else if (take_exc) begin
			status[STATUS_EXL] <= 1'b1;
		end else if (do_eret) begin
			status[STATUS_EXL] <= 1'b0;
		end else if (do_mtc0 && commit_info.mtc0_addr == CP0_STATUS) begin
			status <= commit_info.mtc0_data;
		end
	end

	////////////////////////////////////////////////////////////
	// Cause
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cause <= '0;
		end else begin
			// Hardware interrupt lines sampled every cycle
			cause[15:10] <= hw_int;
			if (take_exc) begin
				cause[CAUSE_BD] <= commit_info.cause_bd;
				cause[6:2]      <= commit_info.cause_exccode;
			end else if (do_mtc0 && commit_info.mtc0_addr == CP0_CAUSE) begin
				// Only the two software interrupt bits are writable
				cause[9:8] <= commit_info.mtc0_data[9:8];
			end
		end
	end

	////////////////////////////////////////////////////////////
	// EPC and BadVAddr
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (take_exc) begin
			epc <= commit_info.epc;
		end else if (do_mtc0 && commit_info.mtc0_addr == CP0_EPC) begin
			epc <= commit_info.mtc0_data;
		end
	end

	always_ff @(posedge clk) begin
		if (take_exc && write_badva) begin
			badvaddr <= commit_info.badvaddr;
		end else if (do_mtc0 && commit_info.mtc0_addr == CP0_BADVADDR) begin
			badvaddr <= commit_info.mtc0_data;
		end
	end

endmodule

// ==== cpu_pkg.sv ====
package cpu_pkg;

	////////////////////////////////////////////////////////////
	// Widths
	////////////////////////////////////////////////////////////

	typedef logic [31:0] vaddr_t;
	typedef logic [31:0] word_t;
	typedef logic [4:0]  exccode_t;
	typedef logic [4:0]  cp0_reg_t;

	// Cause.ExcCode values
	localparam exccode_t EXCCODE_INT  = 5'h00;
	localparam exccode_t EXCCODE_MOD  = 5'h01;
	localparam exccode_t EXCCODE_TLBL = 5'h02;
	localparam exccode_t EXCCODE_TLBS = 5'h03;
	localparam exccode_t EXCCODE_ADEL = 5'h04;
	localparam exccode_t EXCCODE_ADES = 5'h05;
	localparam exccode_t EXCCODE_SYS  = 5'h08;
	localparam exccode_t EXCCODE_BP   = 5'h09;
	localparam exccode_t EXCCODE_RI   = 5'h0a;
	localparam exccode_t EXCCODE_OV   = 5'h0c;

	// CP0 register numbers
	localparam cp0_reg_t CP0_BADVADDR = 5'd8;
	localparam cp0_reg_t CP0_STATUS   = 5'd12;
	localparam cp0_reg_t CP0_CAUSE    = 5'd13;
	localparam cp0_reg_t CP0_EPC      = 5'd14;

	// Bit positions inside Status and Cause
	localparam int STATUS_IE  = 0;
	localparam int STATUS_EXL = 1;
	localparam int CAUSE_BD   = 31;

	localparam vaddr_t EXC_VECTOR    = 32'h8000_0180;
	localparam vaddr_t REFILL_VECTOR = 32'h8000_0000;
	localparam word_t  STATUS_RESET  = 32'h0000_0000;

	////////////////////////////////////////////////////////////
	// Enums
	////////////////////////////////////////////////////////////

	typedef enum logic [1:0] {
		ADDR_ERR_NONE  = 2'b00,
		ADDR_ERR_FETCH = 2'b01,
		ADDR_ERR_LOAD  = 2'b10,
		ADDR_ERR_STORE = 2'b11
	} addr_err_t;

	typedef enum logic [2:0] {
		NONE, REFILL_L, REFILL_S, INVALID_L, INVALID_S, MODIFIED
	} tlb_exc_t;

	typedef enum logic [2:0] {
		TLB_NONE, TLBWI, TLBWR, TLBR, TLBP
	} tlb_req_t;

	typedef enum logic [3:0] {
		OP_NONE, OP_EXC, OP_BADVA, OP_TLB_EXC, OP_ERET,
		OP_MTC0, OP_TLBW, OP_TLBR, OP_TLBP
	} cp0_op_t;

	////////////////////////////////////////////////////////////
	// Lane and result records
	////////////////////////////////////////////////////////////

	typedef struct packed {
		logic      is_instr;
		vaddr_t    pc;
		logic      in_delay_slot;
		vaddr_t    badvaddr;
		addr_err_t addr_err;
		logic      reserved_instr;
		logic      intovf;
		logic      brk;
		logic      syscall;
		logic      eret;
		logic      mtc0;
		cp0_reg_t  mtc0_addr;
		word_t     mtc0_data;
		tlb_req_t  tlb_req;
		tlb_exc_t  tlb_exc_if;
		tlb_exc_t  tlb_exc_mem;
	} lane_in_t;

	typedef struct packed {
		logic     is_valid_exc;
		cp0_op_t  cp0_op;
		exccode_t cause_exccode;
		logic     cause_bd;
		logic     is_refill;
		vaddr_t   epc;
		vaddr_t   badvaddr;
		cp0_reg_t mtc0_addr;
		word_t    mtc0_data;
	} exc_info_t;

endpackage

// ==== exc_commit.sv ====
`timescale 1ns/1ps

module exc_commit import cpu_pkg::*; #(
	parameter int LANES = 2
) (
	input  exc_info_t [LANES-1:0] lane_info,
	input  word_t                 cp0_status,
	input  vaddr_t                cp0_epc,
	output exc_info_t             commit_info,
	output logic                  flush,
	output vaddr_t                redirect_pc,
	output logic      [LANES-1:0] lane_kill,
	output tlb_req_t              tlb_op
);

	localparam int IDX_W = (LANES > 1) ? $clog2(LANES) : 1;

	logic             win_found;
	logic [IDX_W-1:0] win_idx;

	// Lane 0 is the oldest, so the first hit wins
	always_comb begin
		win_found = 1'b0;
		win_idx   = '0;
		for (int i = 0; i < LANES; i++) begin
			if (!win_found && lane_info[i].cp0_op != OP_NONE) begin
				win_found = 1'b1;
				win_idx   = i[IDX_W-1:0];
			end
		end
	end

	always_comb begin
		for (int i = 0; i < LANES; i++) begin
			lane_kill[i] = win_found && (i > int'(win_idx));
		end
	end

	assign commit_info = win_found ? lane_info[win_idx] : '0;

	assign flush = commit_info.is_valid_exc || (commit_info.cp0_op == OP_ERET);

	////////////////////////////////////////////////////////////
	// Redirect target and TLB strobe
	////////////////////////////////////////////////////////////

	always_comb begin
		if (commit_info.is_refill && !cp0_status[STATUS_EXL]) begin
			redirect_pc = REFILL_VECTOR;
		end else if (commit_info.cp0_op == OP_ERET) begin
			redirect_pc = cp0_epc;
		end else begin
			redirect_pc = EXC_VECTOR;
		end
	end

	always_comb begin
		case (commit_info.cp0_op)
			// TLB writes leave as the indexed kind
			OP_TLBW: tlb_op = TLBWI;
			OP_TLBR: tlb_op = TLBR;
			OP_TLBP: tlb_op = TLBP;
			default: tlb_op = TLB_NONE;
		endcase
	end

endmodule

// ==== exc_handler.sv ====
`timescale 1ns/1ps

module exc_handler import cpu_pkg::*; (
	input  lane_in_t   lane,
	input  word_t      cp0_status,
	input  word_t      cp0_cause,
	input  vaddr_t     cp0_epc,
	input  logic [5:0] hw_int,
	output exc_info_t  info
);

	logic [7:0] int_pending;
	logic       int_taken;
	exccode_t   exc_code;
	cp0_op_t    op;
	logic       refill;
	vaddr_t     epc_sel;
	logic       bd_sel;

	// Hardware lines taken straight from the pins, soft bits from Cause
	assign int_pending = {hw_int, cp0_cause[9:8]} & cp0_status[15:8];
	assign int_taken   = (int_pending != 8'b0) && cp0_status[STATUS_IE]
		&& !cp0_status[STATUS_EXL];

	////////////////////////////////////////////////////////////
	// Exception priority
	////////////////////////////////////////////////////////////

	always_comb begin
		exc_code = '0;
		op       = OP_NONE;
		refill   = 1'b0;
		if (!lane.is_instr) begin
			op = OP_NONE;
		end else if (int_taken) begin
			exc_code = EXCCODE_INT;
			op       = OP_EXC;
		end else if (lane.addr_err == ADDR_ERR_FETCH) begin
			exc_code = EXCCODE_ADEL;
			op       = OP_BADVA;
		end else if (lane.tlb_exc_if == REFILL_L || lane.tlb_exc_if == INVALID_L) begin
			exc_code = EXCCODE_TLBL;
			op       = OP_TLB_EXC;
			refill   = (lane.tlb_exc_if == REFILL_L);
		end else if (lane.reserved_instr) begin
			exc_code = EXCCODE_RI;
			op       = OP_EXC;
		end else if (lane.intovf) begin
			exc_code = EXCCODE_OV;
			op       = OP_EXC;
		end else if (lane.brk) begin
			exc_code = EXCCODE_BP;
			op       = OP_EXC;
		end else if (lane.syscall) begin
			exc_code = EXCCODE_SYS;
			op       = OP_EXC;
		end else if (lane.addr_err == ADDR_ERR_LOAD) begin
			exc_code = EXCCODE_ADEL;
			op       = OP_BADVA;
		end else if (lane.addr_err == ADDR_ERR_STORE) begin
			exc_code = EXCCODE_ADES;
			op       = OP_BADVA;
		end else if (lane.tlb_exc_mem != NONE) begin
			op = OP_TLB_EXC;
			case (lane.tlb_exc_mem)
				REFILL_L:  exc_code = EXCCODE_TLBL;
				REFILL_S:  exc_code = EXCCODE_TLBS;
				INVALID_L: exc_code = EXCCODE_TLBL;
				INVALID_S: exc_code = EXCCODE_TLBS;
				default:   exc_code = EXCCODE_MOD;
			endcase
			refill = (lane.tlb_exc_mem == REFILL_L) || (lane.tlb_exc_mem == REFILL_S);
		end else if (lane.eret) begin
			op = OP_ERET;
		end else if (lane.mtc0) begin
			op = OP_MTC0;
		end else if (lane.tlb_req == TLBWI || lane.tlb_req == TLBWR) begin
			op = OP_TLBW;
		end else if (lane.tlb_req == TLBR) begin
			op = OP_TLBR;
		end else if (lane.tlb_req == TLBP) begin
			op = OP_TLBP;
		end
	end

	////////////////////////////////////////////////////////////
	// EPC and branch delay
	////////////////////////////////////////////////////////////

	always_comb begin
		if (cp0_status[STATUS_EXL]) begin
			// Nested exception keeps the first return point
			epc_sel = cp0_epc;
			bd_sel  = cp0_cause[CAUSE_BD];
		end else if (lane.in_delay_slot) begin
			epc_sel = lane.pc - 32'd4;
			bd_sel  = 1'b1;
		end else begin
			epc_sel = lane.pc;
			bd_sel  = 1'b0;
		end
	end

	always_comb begin
		info.is_valid_exc  = (op == OP_EXC) || (op == OP_BADVA) || (op == OP_TLB_EXC);
		info.cp0_op        = op;
		info.cause_exccode = exc_code;
		info.cause_bd      = bd_sel;
		info.is_refill     = refill;
		info.epc           = epc_sel;
		info.badvaddr      = lane.badvaddr;
		info.mtc0_addr     = lane.mtc0_addr;
		info.mtc0_data     = lane.mtc0_data;
	end

endmodule

// ==== exc_unit_checker.sv ====
`timescale 1ns/1ps

module exc_unit_checker import cpu_pkg::*; #(
	parameter int LANES = 2
) (
	input logic                  clk,
	input logic                  rst_n,
	input logic                  flush,
	input logic      [LANES-1:0] lane_kill,
	input tlb_req_t              tlb_op,
	input exc_info_t [LANES-1:0] lane_info
);

	int               fail_cnt = 0;
	logic [LANES-1:0] older_event;

	// Set when some older lane carries a CP0 event
	always_comb begin
		for (int i = 0; i < LANES; i++) begin
			older_event[i] = 1'b0;
			for (int j = 0; j < i; j++) begin
				if (lane_info[j].cp0_op != OP_NONE) begin
					older_event[i] = 1'b1;
				end
			end
		end
	end

	kill_needs_older: assert property (@(posedge clk) disable iff (!rst_n)
		(lane_kill & ~older_event) == '0)
		else begin
			$error("lane_kill set without an event in an older lane");
			fail_cnt++;
		end

	oldest_not_killed: assert property (@(posedge clk) disable iff (!rst_n)
		!lane_kill[0])
		else begin
			$error("lane 0 killed");
			fail_cnt++;
		end

	flush_tlb_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
		!(flush && tlb_op != TLB_NONE))
		else begin
			$error("flush and tlb_op active together");
			fail_cnt++;
		end

	quiet_after_reset: assert property (@(posedge clk)
		$rose(rst_n) |-> (!flush && lane_kill == '0 && tlb_op == TLB_NONE))
		else begin
			$error("output active right after reset release");
			fail_cnt++;
		end

endmodule

bind exc_unit_top exc_unit_checker #(.LANES(LANES)) u_checker (
	.clk       (clk),
	.rst_n     (rst_n),
	.flush     (flush),
	.lane_kill (lane_kill),
	.tlb_op    (tlb_op),
	.lane_info (lane_info)
);

// ==== exc_unit_top.f ====
cpu_pkg.sv
mem_lane_latch.sv
exc_handler.sv
exc_commit.sv
cp0_regs.sv
exc_unit_top.sv
exc_unit_checker.sv
tb_exc_unit.sv

// ==== exc_unit_top.sv ====
`timescale 1ns/1ps

module exc_unit_top import cpu_pkg::*; #(
	parameter int LANES = 2
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic [5:0]           hw_int,
	input  lane_in_t [LANES-1:0] lanes_in,
	output logic                 flush,
	output vaddr_t               redirect_pc,
	output logic     [LANES-1:0] lane_kill,
	output tlb_req_t             tlb_op,
	output word_t                status,
	output word_t                cause,
	output vaddr_t               epc,
	output vaddr_t               badvaddr
);

	lane_in_t  [LANES-1:0] lane_q;
	exc_info_t [LANES-1:0] lane_info;
	exc_info_t             commit_info;
	word_t                 cp0_status;
	word_t                 cp0_cause;
	vaddr_t                cp0_epc;

	mem_lane_latch #(.LANES(LANES)) u_latch (
		.clk      (clk),
		.rst_n    (rst_n),
		.flush    (flush),
		.lanes_in (lanes_in),
		.lane_q   (lane_q)
	);

	// One handler per lane, all reading the same CP0 state
	genvar g;
	generate
		for (g = 0; g < LANES; g++) begin : g_handler
			exc_handler u_handler (
				.lane       (lane_q[g]),
				.cp0_status (cp0_status),
				.cp0_cause  (cp0_cause),
				.cp0_epc    (cp0_epc),
				.hw_int     (hw_int),
				.info       (lane_info[g])
			);
		end
	endgenerate

	exc_commit #(.LANES(LANES)) u_commit (
		.lane_info   (lane_info),
		.cp0_status  (cp0_status),
		.cp0_epc     (cp0_epc),
		.commit_info (commit_info),
		.flush       (flush),
		.redirect_pc (redirect_pc),
		.lane_kill   (lane_kill),
		.tlb_op      (tlb_op)
	);

	cp0_regs u_cp0 (
		.clk         (clk),
		.rst_n       (rst_n),
		.commit_info (commit_info),
		.hw_int      (hw_int),
		.status      (cp0_status),
		.cause       (cp0_cause),
		.epc         (cp0_epc),
		.badvaddr    (badvaddr)
	);

	assign status = cp0_status;
	assign cause  = cp0_cause;
	assign epc    = cp0_epc;

endmodule

// ==== mem_lane_latch.sv ====
`timescale 1ns/1ps

module mem_lane_latch import cpu_pkg::*; #(
	parameter int LANES = 2
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 flush,
	input  lane_in_t [LANES-1:0] lanes_in,
	output lane_in_t [LANES-1:0] lane_q
);

	// Valid bits and lane payload are held apart
	logic     [LANES-1:0] valid_q;
	lane_in_t [LANES-1:0] payload_q;

	////////////////////////////////////////////////////////////
	// Memory to writeback boundary
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			valid_q <= '0;
		end else if (flush) begin
			// Incoming group is younger than the flushing instruction
			valid_q <= '0;
		end else begin
			for (int i = 0; i < LANES; i++) begin
				valid_q[i] <= lanes_in[i].is_instr;
			end
		end
	end

	always_ff @(posedge clk) begin
		payload_q <= lanes_in;
	end

	// Rebuild each lane with the registered valid bit
	genvar g;
	generate
		for (g = 0; g < LANES; g++) begin : g_lane
			always_comb begin
				lane_q[g] = payload_q[g];
				lane_q[g].is_instr = valid_q[g];
			end
		end
	endgenerate

endmodule

// ==== tb_exc_unit.sv ====
`timescale 1ns/1ps

module tb_exc_unit import cpu_pkg::*; ();

	localparam int LANES = 2;

	logic                 clk = 1'b0;
	logic                 rst_n;
	logic [5:0]           hw_int;
	lane_in_t [LANES-1:0] lanes_in;
	logic                 flush;
	vaddr_t               redirect_pc;
	logic     [LANES-1:0] lane_kill;
	tlb_req_t             tlb_op;
	word_t                status;
	word_t                cause;
	vaddr_t               epc;
	vaddr_t               badvaddr;

	integer seed;
	int     err_cnt = 0;
	int     test_cnt = 0;
	int     test_fail = 0;
	int     assert_fails;
	// Return point the CP0 model expects after the last exception
	vaddr_t exp_epc;

	exc_unit_top #(.LANES(LANES)) dut0 (
		.clk         (clk),
		.rst_n       (rst_n),
		.hw_int      (hw_int),
		.lanes_in    (lanes_in),
		.flush       (flush),
		.redirect_pc (redirect_pc),
		.lane_kill   (lane_kill),
		.tlb_op      (tlb_op),
		.status      (status),
		.cause       (cause),
		.epc         (epc),
		.badvaddr    (badvaddr)
	);

	always #2 clk = ~clk;

	////////////////////////////////////////////////////////////
	// Stimulus helpers
	////////////////////////////////////////////////////////////

	function automatic vaddr_t rand_pc();
		vaddr_t p;
		p = 32'($random(seed));
		p[1:0] = 2'b00;
		return p;
	endfunction

	function automatic lane_in_t plain_instr(input vaddr_t pc);
		lane_in_t l;
		l = '0;
		l.is_instr = 1'b1;
		l.pc = pc;
		return l;
	endfunction

	// One group for one cycle, then idle lanes
	task automatic send_group(input lane_in_t l0, input lane_in_t l1);
		@(posedge clk);
		lanes_in <= {l1, l0};
		@(posedge clk);
		lanes_in <= '0;
	endtask

	task automatic wait_outcome(input string what);
		int  n;
		bit  seen;
		seen = 1'b0;
		for (n = 0; n < 20 && !seen; n++) begin
			@(negedge clk);
			seen = flush || (tlb_op != TLB_NONE);
		end
		if (!seen) begin
			$display("Timeout: no flush or TLB strobe within 20 cycles during %s", what);
			err_cnt++;
		end
	endtask

	task automatic wait_status(input word_t exp_v);
		int  n;
		bit  seen;
		seen = 1'b0;
		for (n = 0; n < 20 && !seen; n++) begin
			@(negedge clk);
			seen = (status === exp_v);
		end
		if (!seen) begin
			$display("Timeout: Status never took the value written by mtc0");
			err_cnt++;
		end
	endtask

	////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////

	task automatic check_val(input string name, input word_t exp_v, input word_t act_v);
		assert (act_v === exp_v) else begin
			$display("[ERROR] %s expected %h actual %h", name, exp_v, act_v);
			err_cnt++;
		end
	endtask

	task automatic check_outcome(input logic exp_flush, input vaddr_t exp_pc,
		input logic [LANES-1:0] exp_kill);
		check_val("flush", 32'(exp_flush), 32'(flush));
		check_val("lane_kill", 32'(exp_kill), 32'(lane_kill));
		if (exp_flush) begin
			check_val("redirect_pc", exp_pc, redirect_pc);
		end
	endtask

	// CP0 state one edge after the committing cycle
	task automatic check_cp0(input exccode_t exp_code, input vaddr_t exp_pc, input logic exp_exl);
		@(posedge clk);
		@(negedge clk);
		check_val("cause.exccode", 32'(exp_code), 32'(cause[6:2]));
		check_val("epc", exp_pc, epc);
		check_val("status.exl", 32'(exp_exl), 32'(status[STATUS_EXL]));
	endtask

	task automatic return_from_exc();
		lane_in_t l0;
		l0 = plain_instr(rand_pc());
		l0.eret = 1'b1;
		send_group(l0, '0);
		wait_outcome("eret");
		check_outcome(1'b1, exp_epc, 2'b10);
		@(posedge clk);
		@(negedge clk);
		check_val("status.exl", 32'd0, 32'(status[STATUS_EXL]));
	endtask

	task automatic end_test(input string name, input int errs_before);
		test_cnt++;
		if (err_cnt == errs_before) begin
			$display("%s: ok", name);
		end else begin
			$display("%s: FAILED", name);
			test_fail++;
		end
	endtask

	////////////////////////////////////////////////////////////
	// Tests
	////////////////////////////////////////////////////////////

	task automatic test_ri_young_lane();
		int       errs;
		lane_in_t l0;
		lane_in_t l1;
		vaddr_t   pc;
		errs = err_cnt;
		pc = rand_pc();
		l0 = plain_instr(pc);
		l1 = plain_instr(pc + 32'd4);
		l1.reserved_instr = 1'b1;
		send_group(l0, l1);
		wait_outcome("reserved instruction");
		// Youngest lane wins, nothing behind it to kill
		check_outcome(1'b1, EXC_VECTOR, 2'b00);
		exp_epc = pc + 32'd4;
		check_cp0(EXCCODE_RI, exp_epc, 1'b1);
		return_from_exc();
		end_test("reserved instruction in lane 1", errs);
	endtask

	task automatic test_delay_slot_syscall();
		int       errs;
		lane_in_t l0;
		lane_in_t l1;
		vaddr_t   pc;
		errs = err_cnt;
		pc = rand_pc();
		l0 = plain_instr(pc);
		l0.in_delay_slot = 1'b1;
		l0.syscall = 1'b1;
		l1 = plain_instr(pc + 32'd4);
		send_group(l0, l1);
		wait_outcome("delay slot syscall");
		check_outcome(1'b1, EXC_VECTOR, 2'b10);
		exp_epc = pc - 32'd4;
		check_cp0(EXCCODE_SYS, exp_epc, 1'b1);
		check_val("cause.bd", 32'd1, 32'(cause[CAUSE_BD]));
		return_from_exc();
		end_test("syscall in delay slot", errs);
	endtask

	task automatic test_priority();
		int       errs;
		lane_in_t l0;
		lane_in_t l1;
		vaddr_t   pc;
		errs = err_cnt;
		// Fetch address error outranks syscall in the same lane
		pc = rand_pc() | 32'h1;
		l0 = plain_instr(pc);
		l0.addr_err = ADDR_ERR_FETCH;
		l0.syscall = 1'b1;
		l0.badvaddr = pc;
		l1 = plain_instr(pc + 32'd4);
		send_group(l0, l1);
		wait_outcome("fetch address error");
		check_outcome(1'b1, EXC_VECTOR, 2'b10);
		exp_epc = pc;
		check_cp0(EXCCODE_ADEL, exp_epc, 1'b1);
		check_val("badvaddr", pc, badvaddr);
		return_from_exc();
		// Older lane break beats younger overflow
		pc = rand_pc();
		l0 = plain_instr(pc);
		l0.brk = 1'b1;
		l1 = plain_instr(pc + 32'd4);
		l1.intovf = 1'b1;
		send_group(l0, l1);
		wait_outcome("break against overflow");
		check_outcome(1'b1, EXC_VECTOR, 2'b10);
		exp_epc = pc;
		check_cp0(EXCCODE_BP, exp_epc, 1'b1);
		return_from_exc();
		end_test("exception priority", errs);
	endtask

	task automatic test_tlb();
		int       errs;
		lane_in_t l0;
		lane_in_t l1;
		vaddr_t   pc;
		errs = err_cnt;
		pc = rand_pc();
		l0 = plain_instr(pc);
		l1 = plain_instr(pc + 32'd4);
		l1.tlb_exc_mem = REFILL_S;
		l1.badvaddr = rand_pc();
		send_group(l0, l1);
		wait_outcome("TLB store refill");
		check_outcome(1'b1, REFILL_VECTOR, 2'b00);
		exp_epc = pc + 32'd4;
		check_cp0(EXCCODE_TLBS, exp_epc, 1'b1);
		check_val("badvaddr", l1.badvaddr, badvaddr);
		// EXL still set from the refill
		pc = rand_pc();
		l0 = plain_instr(pc);
		l0.tlb_exc_mem = MODIFIED;
		l1 = plain_instr(pc + 32'd4);
		send_group(l0, l1);
		wait_outcome("TLB modified");
		check_outcome(1'b1, EXC_VECTOR, 2'b10);
		check_cp0(EXCCODE_MOD, exp_epc, 1'b1);
		return_from_exc();
		end_test("TLB refill and modified", errs);
	endtask

	task automatic test_eret_tlbp();
		int       errs;
		lane_in_t l0;
		lane_in_t l1;
		vaddr_t   pc;
		errs = err_cnt;
		pc = rand_pc();
		l0 = plain_instr(pc);
		l0.syscall = 1'b1;
		send_group(l0, '0);
		wait_outcome("syscall before eret");
		check_outcome(1'b1, EXC_VECTOR, 2'b10);
		exp_epc = pc;
		check_cp0(EXCCODE_SYS, exp_epc, 1'b1);
		return_from_exc();
		pc = rand_pc();
		l0 = plain_instr(pc);
		l0.tlb_req = TLBP;
		l1 = plain_instr(pc + 32'd4);
		send_group(l0, l1);
		wait_outcome("TLBP");
		check_val("tlb_op", 32'(TLBP), 32'(tlb_op));
		check_outcome(1'b0, EXC_VECTOR, 2'b10);
		end_test("eret and TLBP", errs);
	endtask

	task automatic test_interrupt();
		int       errs;
		lane_in_t l0;
		lane_in_t l1;
		vaddr_t   pc;
		errs = err_cnt;
		l0 = plain_instr(rand_pc());
		l0.mtc0 = 1'b1;
		l0.mtc0_addr = CP0_STATUS;
		// IM[2] at bit 10, IE at bit 0
		l0.mtc0_data = 32'h0000_0401;
		send_group(l0, '0);
		wait_status(32'h0000_0401);
		@(posedge clk);
		hw_int <= 6'b000001;
		pc = rand_pc();
		l0 = plain_instr(pc);
		l1 = plain_instr(pc + 32'd4);
		send_group(l0, l1);
		wait_outcome("interrupt");
		check_outcome(1'b1, EXC_VECTOR, 2'b10);
		exp_epc = pc;
		check_cp0(EXCCODE_INT, exp_epc, 1'b1);
		// Cause IP[7:2] mirrors the interrupt pins
		check_val("cause.ip", 32'h0000_0001, 32'(cause[15:10]));
		@(posedge clk);
		hw_int <= '0;
		end_test("hardware interrupt", errs);
	endtask

	initial begin
		seed = 32'h6faf_3fae;
		rst_n = 1'b0;
		hw_int = '0;
		lanes_in = '0;
		exp_epc = '0;
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;
		test_ri_young_lane();
		test_delay_slot_syscall();
		test_priority();
		test_tlb();
		test_eret_tlbp();
		test_interrupt();
		repeat (2) @(posedge clk);
		assert_fails = dut0.u_checker.fail_cnt;
		$display("Summary: %0d tests, %0d failed, %0d check errors, %0d assertion failures",
			test_cnt, test_fail, err_cnt, assert_fails);
		if (err_cnt != 0 || test_fail != 0 || assert_fails != 0) begin
			$display("Test failures found");
		end else begin
			$display("All tests passed!");
		end
		$finish;
	end

endmodule
